//--- design/rv_ctrl_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_ctrl_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          fields_valid_i,
    input  rv_decode_pkg::decode_fields_t fields_i,
    output logic                          out_valid_o,     // Two cycles after the strobe
    output rv_decode_pkg::decode_ctrl_t   ctrl_o
);
    import rv_decode_pkg::*;

    decode_ctrl_t ctrl_d;
    logic         shift_right;

    assign shift_right = (fields_i.funct3 == `RV_F3_SRL_SRA);  // Only place OP_IMM uses funct7

    always_comb begin
        ctrl_d.alu_op     = ALU_OP_ADD;  // Address and link arithmetic all use ADD
        ctrl_d.br_op      = BR_NOOP;
        ctrl_d.load_op    = LOAD_LW;
        ctrl_d.store_op   = STORE_SB;
        ctrl_d.src_sel    = SRC_REGS;
        ctrl_d.mem_rd     = 1'b0;
        ctrl_d.mem_wr     = 1'b0;
        ctrl_d.mem_be     = '0;
        ctrl_d.regfile_wr = 1'b0;
        ctrl_d.jump       = 1'b0;
        ctrl_d.jalr       = 1'b0;
        ctrl_d.illegal    = 1'b0;
        ctrl_d.rs1        = fields_i.rs1;
        ctrl_d.rs2        = fields_i.rs2;
        ctrl_d.rd         = fields_i.rd;
        ctrl_d.imm        = fields_i.imm;
        case (fields_i.op_class)
            CLASS_LUI: begin
                ctrl_d.src_sel    = SRC_IMM_RS1;
                ctrl_d.rs1        = '0;  // x0 plus the immediate gives the LUI value
                ctrl_d.regfile_wr = 1'b1;
            end
            CLASS_AUIPC, CLASS_JAL: begin
                ctrl_d.src_sel    = SRC_IMM_PC;  // Target or result is PC plus the immediate
                ctrl_d.regfile_wr = 1'b1;
                ctrl_d.jump       = 1'b1;
            end
            CLASS_JALR: begin
                ctrl_d.src_sel    = SRC_IMM_RS1;
                ctrl_d.regfile_wr = 1'b1;
                ctrl_d.jump       = 1'b1;
                ctrl_d.jalr       = 1'b1;  // Target comes from rs1, not the PC
            end
            CLASS_BRANCH: begin
                case (fields_i.funct3)
                    `RV_F3_BEQ:  ctrl_d.br_op = BR_EQ;
                    `RV_F3_BNE:  ctrl_d.br_op = BR_NE;
                    `RV_F3_BLT:  ctrl_d.br_op = BR_LT;
                    `RV_F3_BGE:  ctrl_d.br_op = BR_GE;
                    `RV_F3_BLTU: ctrl_d.br_op = BR_LTU;
                    `RV_F3_BGEU: ctrl_d.br_op = BR_GEU;
                    default:     ctrl_d.illegal = 1'b1;  // Funct3 010 and 011 are reserved
                endcase
            end
            CLASS_LOAD: begin
                ctrl_d.src_sel    = SRC_IMM_RS1;
                ctrl_d.mem_rd     = 1'b1;
                ctrl_d.regfile_wr = 1'b1;
                case (fields_i.funct3)
                    `RV_F3_LB:  ctrl_d.load_op = LOAD_LB;
                    `RV_F3_LH:  ctrl_d.load_op = LOAD_LH;
                    `RV_F3_LW:  ctrl_d.load_op = LOAD_LW;
                    `RV_F3_LBU: ctrl_d.load_op = LOAD_LBU;
                    `RV_F3_LHU: ctrl_d.load_op = LOAD_LHU;
                    default:    ctrl_d.illegal = 1'b1;
                endcase
            end
            CLASS_STORE: begin
                ctrl_d.src_sel = SRC_IMM_RS1;
                ctrl_d.mem_wr  = 1'b1;
                case (fields_i.funct3)
                    `RV_F3_SB: begin
                        ctrl_d.store_op = STORE_SB;
                        ctrl_d.mem_be   = 4'b0001;  // Low byte lane
                    end
                    `RV_F3_SH: begin
                        ctrl_d.store_op = STORE_SH;
                        ctrl_d.mem_be   = 4'b0011;  // Low halfword
                    end
                    `RV_F3_SW: begin
                        ctrl_d.store_op = STORE_SW;
                        ctrl_d.mem_be   = 4'b1111;
                    end
                    default: ctrl_d.illegal = 1'b1;
                endcase
            end
            CLASS_OP_IMM: begin
                ctrl_d.src_sel    = SRC_IMM_RS1;
                ctrl_d.regfile_wr = 1'b1;
                // Bit 30 is immediate data except on SRLI/SRAI
                ctrl_d.alu_op = alu_op_e'({1'b0, shift_right & fields_i.funct7_b5,
                                           fields_i.funct3});
            end
            CLASS_OP: begin
                ctrl_d.regfile_wr = 1'b1;
                ctrl_d.alu_op = alu_op_e'({fields_i.funct7_b0, fields_i.funct7_b5,
                                           fields_i.funct3});  // The ALU decodes the rest
            end
            default: begin
                ctrl_d.illegal = 1'b1;  // FENCE, SYSTEM and unknown opcodes
            end
        endcase
        if (ctrl_d.illegal) begin
            ctrl_d.regfile_wr = 1'b0;  // An illegal word must leave no architectural trace
            ctrl_d.mem_rd     = 1'b0;
            ctrl_d.mem_wr     = 1'b0;
            ctrl_d.mem_be     = '0;
            ctrl_d.jump       = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o       <= 1'b0;
            ctrl_o.mem_rd     <= 1'b0;
            ctrl_o.mem_wr     <= 1'b0;
            ctrl_o.mem_be     <= '0;
            ctrl_o.regfile_wr <= 1'b0;
            ctrl_o.jump       <= 1'b0;
            ctrl_o.illegal    <= 1'b0;
        end else begin
            out_valid_o <= fields_valid_i;
            if (fields_valid_i) begin
                ctrl_o <= ctrl_d;  // Held while no instruction is in this stage
            end
        end
    end

    a_illegal_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && ctrl_o.illegal |-> !ctrl_o.regfile_wr && !ctrl_o.mem_wr && !ctrl_o.mem_rd);

    a_be_only_on_store: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ctrl_o.mem_be != '0) |-> ctrl_o.mem_wr);

endmodule

`default_nettype wire

//--- design/rv_decode_macros.svh
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// Datapath and instruction width
`define RV_XLEN         32
`define RV_REG_ADDR_W   5                   // Register file address width
`define RV_BE_W         4                   // One enable per byte of a data word

// Major opcodes, bits [6:0] of the instruction word
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_AUIPC    7'b0010111
`define RV_OPC_JAL      7'b1101111
`define RV_OPC_JALR     7'b1100111
`define RV_OPC_BRANCH   7'b1100011
`define RV_OPC_LOAD     7'b0000011
`define RV_OPC_STORE    7'b0100011
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_OP       7'b0110011
`define RV_OPC_FENCE    7'b0001111          // Not decoded, ends up illegal
`define RV_OPC_SYSTEM   7'b1110011          // Not decoded, ends up illegal

// Branch funct3
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_BLT       3'b100
`define RV_F3_BGE       3'b101
`define RV_F3_BLTU      3'b110
`define RV_F3_BGEU      3'b111

// Load funct3
`define RV_F3_LB        3'b000
`define RV_F3_LH        3'b001
`define RV_F3_LW        3'b010
`define RV_F3_LBU       3'b100
`define RV_F3_LHU       3'b101

// Store funct3
`define RV_F3_SB        3'b000
`define RV_F3_SH        3'b001
`define RV_F3_SW        3'b010

`define RV_F3_SRL_SRA   3'b101              // Shift right, funct7 bit 5 picks arithmetic

`endif

//--- design/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_macros.svh"

package rv_decode_pkg;

    typedef enum logic [3:0] {
        CLASS_LUI     = 4'd0,
        CLASS_AUIPC   = 4'd1,
        CLASS_JAL     = 4'd2,
        CLASS_JALR    = 4'd3,
        CLASS_BRANCH  = 4'd4,
        CLASS_LOAD    = 4'd5,
        CLASS_STORE   = 4'd6,
        CLASS_OP_IMM  = 4'd7,
        CLASS_OP      = 4'd8,
        CLASS_ILLEGAL = 4'd9              // Any opcode not decoded here, FENCE and SYSTEM too
    } op_class_e;

    // ALU code is {M extension, alternate (SUB/SRA), funct3}
    typedef enum logic [4:0] {
        ALU_OP_ADD    = 5'b00000,
        ALU_OP_SLL    = 5'b00001,
        ALU_OP_SLT    = 5'b00010,
        ALU_OP_SLTU   = 5'b00011,
        ALU_OP_XOR    = 5'b00100,
        ALU_OP_SRL    = 5'b00101,
        ALU_OP_OR     = 5'b00110,
        ALU_OP_AND    = 5'b00111,
        ALU_OP_SUB    = 5'b01000,
        ALU_OP_SRA    = 5'b01101,
        ALU_OP_MUL    = 5'b10000,
        ALU_OP_MULH   = 5'b10001,
        ALU_OP_MULHSU = 5'b10010,
        ALU_OP_MULHU  = 5'b10011,
        ALU_OP_DIV    = 5'b10100,
        ALU_OP_DIVU   = 5'b10101,
        ALU_OP_REM    = 5'b10110,
        ALU_OP_REMU   = 5'b10111
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NOOP = 3'd0, BR_EQ = 3'd1, BR_NE = 3'd2, BR_LT = 3'd3,
        BR_LTU  = 3'd4, BR_GE = 3'd5, BR_GEU = 3'd6
    } br_op_e;

    typedef enum logic [2:0] {
        LOAD_LB = 3'd0, LOAD_LH = 3'd1, LOAD_LW = 3'd2, LOAD_LBU = 3'd3, LOAD_LHU = 3'd4
    } load_op_e;

    typedef enum logic [1:0] {
        STORE_SB = 2'd0, STORE_SH = 2'd1, STORE_SW = 2'd2
    } store_op_e;

    typedef enum logic [1:0] {
        SRC_REGS    = 2'd0,                 // rs1 and rs2
        SRC_IMM_RS1 = 2'd1,                 // rs1 and the immediate
        SRC_IMM_PC  = 2'd2                  // PC and the immediate
    } src_sel_e;

    typedef struct packed {
        op_class_e                 op_class;
        logic [2:0]                funct3;
        logic                      funct7_b0;   // Selects the M extension on OP
        logic                      funct7_b5;   // Selects SUB and SRA
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       imm;         // Already sign extended for its format
    } decode_fields_t;

    typedef struct packed {
        alu_op_e                   alu_op;
        br_op_e                    br_op;
        load_op_e                  load_op;
        store_op_e                 store_op;
        src_sel_e                  src_sel;
        logic                      mem_rd;
        logic                      mem_wr;
        logic [`RV_BE_W-1:0]       mem_be;
        logic                      regfile_wr;
        logic                      jump;
        logic                      jalr;
        logic                      illegal;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       imm;
    } decode_ctrl_t;

endpackage

`default_nettype wire

//--- design/rv_decode_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decode_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        instr_valid_i,  // No back-pressure, one word per cycle
    input  logic [`RV_XLEN-1:0]         instr_i,
    output logic                        out_valid_o,
    output rv_decode_pkg::decode_ctrl_t ctrl_o
);
    import rv_decode_pkg::*;

    logic           fields_valid;  // Stage 1 to stage 2 valid
    decode_fields_t fields;

    rv_field_stage u_field_stage (  // Classifies and slices the instruction word
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .fields_valid_o (fields_valid),
        .fields_o       (fields)
    );

    rv_ctrl_stage u_ctrl_stage (  // Turns the class and funct bits into controls
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fields_valid_i (fields_valid),
        .fields_i       (fields),
        .out_valid_o    (out_valid_o),
        .ctrl_o         (ctrl_o)
    );

endmodule

`default_nettype wire

//--- design/rv_field_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_field_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          instr_valid_i,   // Single cycle strobe
    input  logic [`RV_XLEN-1:0]           instr_i,
    output logic                          fields_valid_o,  // One cycle after the strobe
    output rv_decode_pkg::decode_fields_t fields_o
);
    import rv_decode_pkg::*;

    logic [6:0]          opcode;
    op_class_e           op_class;
    logic [`RV_XLEN-1:0] imm;
    decode_fields_t      fields_d;

    assign opcode = instr_i[6:0];

    always_comb begin
        case (opcode)
            `RV_OPC_LUI:    op_class = CLASS_LUI;
            `RV_OPC_AUIPC:  op_class = CLASS_AUIPC;
            `RV_OPC_JAL:    op_class = CLASS_JAL;
            `RV_OPC_JALR:   op_class = CLASS_JALR;
            `RV_OPC_BRANCH: op_class = CLASS_BRANCH;
            `RV_OPC_LOAD:   op_class = CLASS_LOAD;
            `RV_OPC_STORE:  op_class = CLASS_STORE;
            `RV_OPC_OP_IMM: op_class = CLASS_OP_IMM;
            `RV_OPC_OP:     op_class = CLASS_OP;
            default:        op_class = CLASS_ILLEGAL;   // FENCE, SYSTEM and unknown opcodes
        endcase
    end

    always_comb begin
        case (op_class)
            CLASS_LUI, CLASS_AUIPC: begin
                imm = {instr_i[31:12], 12'b0};  // U format, upper 20 bits
            end
            CLASS_JAL: begin
                imm = {{(`RV_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};  // J format, halfword offset
            end
            CLASS_JALR, CLASS_LOAD, CLASS_OP_IMM: begin
                imm = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};  // I format
            end
            CLASS_STORE: begin
                imm = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};  // S format
            end
            CLASS_BRANCH: begin
                imm = {{(`RV_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};  // B format, halfword offset
            end
            default: begin
                imm = '0;                       // OP and illegal words carry no immediate
            end
        endcase
    end

    always_comb begin
        fields_d.op_class  = op_class;
        fields_d.funct3    = instr_i[14:12];
        fields_d.funct7_b0 = instr_i[25];  // Bit 0 of funct7
        fields_d.funct7_b5 = instr_i[30];  // Bit 5 of funct7
        fields_d.rs1       = instr_i[19:15];
        fields_d.rs2       = instr_i[24:20];
        fields_d.rd        = instr_i[11:7];
        fields_d.imm       = imm;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fields_valid_o <= 1'b0;
        end else begin
            fields_valid_o <= instr_valid_i;  // Follows the strobe with one cycle of delay
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            fields_o <= fields_d;  // Payload holds between strobes
        end
    end

    a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(fields_valid_o));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the decoder testbench with Verilator, runs it and scans the log for failures

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert -f rv_decode.f --top-module tb_rv_decode \
    -Mdir "$OBJ_DIR" -o sim_rv_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/sim_rv_decode" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- rv_decode.f
+incdir+design
+incdir+tb
design/rv_decode_pkg.sv
design/rv_field_stage.sv
design/rv_ctrl_stage.sv
design/rv_decode_top.sv
tb/tb_rv_decode.sv

//--- tb/rv_decode_model.svh
`ifndef RV_DECODE_MODEL_SVH
`define RV_DECODE_MODEL_SVH

// Expected decoder output for one instruction word, worked out from the RV32IM encoding
function automatic decode_ctrl_t expected_ctrl(input logic [31:0] instr);
    decode_ctrl_t e;
    logic [2:0]   f3;
    f3 = instr[14:12];
    e = '0;                                          // ADD, no branch, SB, both register operands
    e.load_op = LOAD_LW;                             // Load type rests at LW when unused
    e.rs1 = instr[19:15];
    e.rs2 = instr[24:20];
    e.rd  = instr[11:7];
    case (instr[6:0])
        `RV_OPC_LUI: begin
            e.imm        = {instr[31:12], 12'h000};
            e.src_sel    = SRC_IMM_RS1;
            e.rs1        = 5'd0;                     // x0 plus the upper immediate
            e.regfile_wr = 1'b1;
        end
        `RV_OPC_AUIPC: begin
            e.imm        = {instr[31:12], 12'h000};
            e.src_sel    = SRC_IMM_PC;
            e.regfile_wr = 1'b1;
            e.jump       = 1'b1;
        end
        `RV_OPC_JAL: begin
            e.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            e.src_sel    = SRC_IMM_PC;
            e.regfile_wr = 1'b1;
            e.jump       = 1'b1;
        end
        `RV_OPC_JALR: begin
            e.imm        = {{20{instr[31]}}, instr[31:20]};
            e.src_sel    = SRC_IMM_RS1;
            e.regfile_wr = 1'b1;
            e.jump       = 1'b1;
            e.jalr       = 1'b1;
        end
        `RV_OPC_BRANCH: begin
            e.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            case (f3)
                3'b000:  e.br_op = BR_EQ;
                3'b001:  e.br_op = BR_NE;
                3'b100:  e.br_op = BR_LT;
                3'b101:  e.br_op = BR_GE;
                3'b110:  e.br_op = BR_LTU;
                3'b111:  e.br_op = BR_GEU;
                default: e.illegal = 1'b1;           // 010 and 011 are reserved
            endcase
        end
        `RV_OPC_LOAD: begin
            e.imm        = {{20{instr[31]}}, instr[31:20]};
            e.src_sel    = SRC_IMM_RS1;
            e.mem_rd     = 1'b1;
            e.regfile_wr = 1'b1;
            case (f3)
                3'b000:  e.load_op = LOAD_LB;
                3'b001:  e.load_op = LOAD_LH;
                3'b010:  e.load_op = LOAD_LW;
                3'b100:  e.load_op = LOAD_LBU;
                3'b101:  e.load_op = LOAD_LHU;
                default: e.illegal = 1'b1;
            endcase
        end
        `RV_OPC_STORE: begin
            e.imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            e.src_sel = SRC_IMM_RS1;
            e.mem_wr  = 1'b1;
            e.illegal = (f3 > 3'b010);
            e.store_op = store_op_e'(f3[1:0]);       // SB, SH and SW count up from zero
            e.mem_be   = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
            if (e.illegal) begin
                e.store_op = STORE_SB;
            end
        end
        `RV_OPC_OP_IMM: begin
            e.imm        = {{20{instr[31]}}, instr[31:20]};
            e.src_sel    = SRC_IMM_RS1;
            e.regfile_wr = 1'b1;
            e.alu_op     = alu_op_e'({1'b0, (f3 == 3'b101) && instr[30], f3});  // SRAI only
        end
        `RV_OPC_OP: begin
            e.regfile_wr = 1'b1;
            e.alu_op     = alu_op_e'({instr[25], instr[30], f3});
        end
        default: e.illegal = 1'b1;                   // FENCE, SYSTEM and anything unknown
    endcase
    if (e.illegal) begin
        e.regfile_wr = 1'b0;                         // Nothing may be written for an illegal word
        e.mem_rd     = 1'b0;
        e.mem_wr     = 1'b0;
        e.mem_be     = 4'b0000;
        e.jump       = 1'b0;
    end
    return e;
endfunction

// One step of a 16-bit Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
endfunction

`endif

//--- tb/tb_rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_decode;
    import rv_decode_pkg::*;

    `include "rv_decode_macros.svh"
    `include "rv_decode_model.svh"

    logic                clk_i;
    logic                rst_n_i;
    logic                instr_valid_i;
    logic [`RV_XLEN-1:0] instr_i;
    logic                out_valid_o;
    decode_ctrl_t        ctrl_o;

    decode_ctrl_t exp_q[$];                          // Expected results in issue order
    int           due_q[$];                          // Cycle in which each result must show
    decode_ctrl_t exp_ctrl;
    int           exp_due;
    int           cycle_cnt = 0;
    int           checks = 0;
    int           errors = 0;
    int           tests = 0;
    int           test_checks;
    int           test_errors;
    string        test_name = "none";
    logic [15:0]  lfsr_state = 16'd49444;

    rv_decode_top dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .out_valid_o   (out_valid_o),
        .ctrl_o        (ctrl_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;                   // 4 ns period
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    initial begin
        #1000000;                                    // Last guard in case a loop bound is wrong
        $display("Simulation stopped by the watchdog at cycle %0d", cycle_cnt);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Returns n LFSR bits with one step per bit and the newest bit at the bottom
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic logic [31:0] with_funct3(input logic [31:0] rnd, input logic [2:0] f3,
                                                input logic [6:0] opc);
        return {rnd[31:15], f3, rnd[11:7], opc};
    endfunction

    function automatic logic [6:0] pick_opcode();
        logic [31:0] sel;
        logic [31:0] raw;
        sel = take_bits(4);
        raw = take_bits(7);
        case (sel[3:0])
            4'd0:    return `RV_OPC_LUI;
            4'd1:    return `RV_OPC_AUIPC;
            4'd2:    return `RV_OPC_JAL;
            4'd3:    return `RV_OPC_JALR;
            4'd4:    return `RV_OPC_BRANCH;
            4'd5:    return `RV_OPC_LOAD;
            4'd6:    return `RV_OPC_STORE;
            4'd7:    return `RV_OPC_OP_IMM;
            4'd8:    return `RV_OPC_OP;
            4'd9:    return `RV_OPC_FENCE;
            4'd10:   return `RV_OPC_SYSTEM;
            default: return raw[6:0];                // Mostly opcodes the decoder does not know
        endcase
    endfunction

    task automatic record_error();
        test_errors++;
        errors++;
    endtask

    task automatic open_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
        tests++;
    endtask

    // Strobes one word and files its expected result two cycles ahead
    task automatic send_instr(input logic [31:0] word);
        @(negedge clk_i);
        instr_valid_i = 1'b1;
        instr_i       = word;
        exp_q.push_back(expected_ctrl(word));
        due_q.push_back(cycle_cnt + 2);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk_i);
            instr_valid_i = 1'b0;
        end
    endtask

    // Waits a bounded time for outstanding results and then prints the line for this test
    task automatic close_test();
        int t;
        idle_cycles(1);
        t = 0;
        while (exp_q.size() != 0 && t < 50) begin
            @(negedge clk_i);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("Test %s timed out with %0d results still missing", test_name, exp_q.size());
            record_error();
            exp_q.delete();
            due_q.delete();
        end
        $display("%-10s %s  checks=%0d errors=%0d", test_name,
                 (test_errors == 0) ? "PASS" : "FAIL", test_checks, test_errors);
    endtask

    // Compares each result at the falling edge where the outputs are steady
    always @(negedge clk_i) begin
        if (rst_n_i && out_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Test %s saw a result with no instruction outstanding", test_name);
                record_error();
            end else begin
                exp_ctrl = exp_q.pop_front();
                exp_due  = due_q.pop_front();
                checks      += 2;
                test_checks += 2;
                assert (ctrl_o === exp_ctrl) else begin
                    $display("ERROR %s: expected %h, actual %h", test_name, exp_ctrl, ctrl_o);
                    record_error();
                end
                assert (cycle_cnt == exp_due) else begin
                    $display("ERROR %s latency: expected cycle %0d, actual cycle %0d",
                             test_name, exp_due, cycle_cnt);
                    record_error();
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] gap;
        logic [8:0]  reset_ctrl;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        open_test("reset");
        repeat (20) begin
            @(negedge clk_i);
            checks      += 2;
            test_checks += 2;
            assert (out_valid_o === 1'b0) else begin
                $display("ERROR %s: expected 0, actual %b", test_name, out_valid_o);
                record_error();
            end
            // Memory, write, jump and illegal controls all come out of reset cleared
            reset_ctrl = {ctrl_o.mem_rd, ctrl_o.mem_wr, ctrl_o.mem_be, ctrl_o.regfile_wr,
                          ctrl_o.jump, ctrl_o.illegal};
            assert (reset_ctrl === 9'd0) else begin
                $display("ERROR %s controls: expected %h, actual %h", test_name, 9'd0,
                         reset_ctrl);
                record_error();
            end
        end
        close_test();

        open_test("u_j_jalr");
        for (int i = 0; i < 20; i++) begin
            r = take_bits(32);
            send_instr({r[31:7], `RV_OPC_LUI});
            r = take_bits(32);
            send_instr({r[31:7], `RV_OPC_AUIPC});
            r = take_bits(32);
            send_instr({r[31:7], `RV_OPC_JAL});
            r = take_bits(32);
            send_instr(with_funct3(r, 3'b000, `RV_OPC_JALR));
        end
        close_test();

        open_test("load_store");
        for (int f = 0; f < 8; f++) begin
            send_instr(with_funct3(take_bits(32), 3'(f), `RV_OPC_LOAD));
            send_instr(with_funct3(take_bits(32), 3'(f), `RV_OPC_STORE));
        end
        close_test();

        open_test("alu");
        for (int i = 0; i < 200; i++) begin
            r = take_bits(32);
            send_instr({r[31:7], `RV_OPC_OP});       // Random funct7 reaches SUB, SRA and M codes
            r = take_bits(32);
            send_instr({r[31:7], `RV_OPC_OP_IMM});
        end
        close_test();

        open_test("branch");
        for (int f = 0; f < 8; f++) begin
            send_instr(with_funct3(take_bits(32), 3'(f), `RV_OPC_BRANCH));
        end
        close_test();

        open_test("random");
        for (int n = 0; n < 2000; n++) begin
            r = take_bits(32);
            send_instr({r[31:7], pick_opcode()});
            if (take_bits(1) == 32'd0) begin     // Otherwise the next strobe is back to back
                gap = take_bits(2);
                idle_cycles(int'(gap) + 1);
            end
        end
        close_test();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
